// File: sources.f
design/eth_gen_pkg.sv
design/tx_beat_if.sv
design/pkt_len_gen.sv
design/ipv4_header_build.sv
design/payload_gen.sv
design/pkt_tx_ctrl.sv
design/frame_assembler.sv
design/eth_pkt_gen.sv
test/eth_gen_properties.sv
test/tb_eth_pkt_gen.sv

// File: Bender.yml
package:
  name: eth_pkt_gen

sources:
  - design/eth_gen_pkg.sv
  - design/tx_beat_if.sv
  - design/pkt_len_gen.sv
  - design/ipv4_header_build.sv
  - design/payload_gen.sv
  - design/pkt_tx_ctrl.sv
  - design/frame_assembler.sv
  - design/eth_pkt_gen.sv
  - target: test
    files:
      - test/eth_gen_properties.sv
      - test/tb_eth_pkt_gen.sv

// File: test/tb_eth_pkt_gen.sv
// Testbench for the frame generator with clock, reset, test phases, sop counting, watchdog and report
`timescale 1ns/1ns

module tb_eth_pkt_gen import eth_gen_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int IDLE_CYCLES = 16;
    // Three phases of up to 20 frames, 50 beats each, with slack for stalls
    localparam int WATCHDOG_NS = 3 * 20 * 50 * 4 * CLK_PERIOD;

    logic                  i_clk;
    logic                  i_reset_n;
    logic                  i_start;
    logic                  i_enable;
    logic                  i_hold_eop;
    logic                  i_random_len;
    logic [LEN_WIDTH-1:0]  i_fixed_len;
    logic                  i_linear_payload;
    logic [31:0]           i_pkt_num;
    logic                  i_ready;
    logic                  o_valid;
    logic [DATA_WIDTH-1:0] o_data;
    logic                  o_sop;
    logic                  o_eop;
    logic [MOD_WIDTH-1:0]  o_mod;

    logic stress_on;
    int   sop_count = 0;
    int   eop_count = 0;

    eth_pkt_gen dut_i (.*);

    bind eth_pkt_gen eth_gen_properties props_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_start(i_start), .i_enable(i_enable),
        .i_hold_eop(i_hold_eop), .i_random_len(i_random_len), .i_fixed_len(i_fixed_len),
        .i_linear_payload(i_linear_payload), .i_ready(i_ready), .i_valid(o_valid),
        .i_data(o_data), .i_sop(o_sop), .i_eop(o_eop), .i_mod(o_mod)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on the first error");
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Sink ready and the enable and hold pauses share one seeded generator
    initial begin
        void'($urandom(8));
        i_ready    = 1'b0;
        i_enable   = 1'b1;
        i_hold_eop = 1'b0;
        forever begin
            @(posedge i_clk);
            #1;
            i_ready = ($urandom % 4) != 0;
            if (stress_on) begin
                i_enable   = ($urandom % 4) != 0;
                i_hold_eop = ($urandom % 3) == 0;
            end else begin
                i_enable   = 1'b1;
                i_hold_eop = 1'b0;
            end
        end
    end

    always @(posedge i_clk) begin
        if (i_reset_n && o_valid && i_ready) begin
            if (o_sop) sop_count <= sop_count + 1;
            if (o_eop) eop_count <= eop_count + 1;
        end
    end

    always @(posedge i_clk) begin
        if (dut_i.props_i.error_count != 0) report_failure("a stream assertion failed");
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the frames were sent");
    end

    // ------------------------------
    // Test phases
    // ------------------------------
    task automatic run_phase(input string name, input logic random_len,
                             input logic [LEN_WIDTH-1:0] fixed_len, input logic linear,
                             input int pkt_num, input logic stress);
        int sops_before;
        int eops_before;
        int sops_seen;
        @(posedge i_clk);
        #1;
        i_random_len     = random_len;
        i_fixed_len      = fixed_len;
        i_linear_payload = linear;
        i_pkt_num        = pkt_num;
        stress_on        = stress;
        sops_before      = sop_count;
        eops_before      = eop_count;
        repeat (2) @(posedge i_clk);
        #1 i_start = 1'b1;
        repeat (4) @(posedge i_clk);
        #1 i_start = 1'b0;
        while (eop_count - eops_before < pkt_num) @(posedge i_clk);
        stress_on = 1'b0;
        // Any frame past the limit would start within these cycles
        repeat (IDLE_CYCLES) @(posedge i_clk);
        sops_seen = sop_count - sops_before;
        if (sops_seen != pkt_num) begin
            report_failure($sformatf("FAILED %s: sop count expected %0d, actual %0d",
                                     name, pkt_num, sops_seen));
        end else begin
            $display("%s: %0d frames sent", name, sops_seen);
        end
    endtask

    initial begin
        i_reset_n        = 1'b0;
        i_start          = 1'b0;
        i_random_len     = 1'b0;
        i_fixed_len      = 16'd46;
        i_linear_payload = 1'b0;
        i_pkt_num        = '0;
        stress_on        = 1'b0;
        repeat (5) @(posedge i_clk);
        #1 i_reset_n = 1'b1;
        repeat (8) @(posedge i_clk);

        run_phase("random_len_random_payload", 1'b1, 16'd46, 1'b0, 20, 1'b0);
        run_phase("fixed_46_linear", 1'b0, 16'd46, 1'b1, 5, 1'b0);
        // Long frames keep linear payload so that beats past the second are checked
        run_phase("fixed_1000_hold_enable", 1'b0, 16'd1000, 1'b1, 8, 1'b1);

        @(posedge i_clk);
        if (dut_i.props_i.error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure("stream assertions reported errors");
        end
    end

endmodule

// File: test/eth_gen_properties.sv
// Bound stream checker for handshake stability, framing, header checksum and length, payload and gating
`timescale 1ns/1ns

module eth_gen_properties import eth_gen_pkg::*; (
    input logic                  i_clk,
    input logic                  i_reset_n,
    input logic                  i_start,
    input logic                  i_enable,
    input logic                  i_hold_eop,
    input logic                  i_random_len,
    input logic [LEN_WIDTH-1:0]  i_fixed_len,
    input logic                  i_linear_payload,
    input logic                  i_ready,
    input logic                  i_valid,
    input logic [DATA_WIDTH-1:0] i_data,
    input logic                  i_sop,
    input logic                  i_eop,
    input logic [MOD_WIDTH-1:0]  i_mod
);

    int error_count = 0;

    logic        xfer;
    logic [15:0] ip_len;
    logic [15:0] second_word;
    logic        started_q;
    logic        in_frame_q;
    logic [15:0] beats_q;
    logic [15:0] frame_len_q;
    logic [31:0] csum_part_q;

    // Sum of the IPv4 header words found in the sop beat, bytes 14 to 31
    function automatic logic [31:0] header_word_sum(input logic [DATA_WIDTH-1:0] d);
        logic [31:0] s;
        s = '0;
        for (int k = 7; k < 16; k++) begin
            s = s + {16'h0000, d[8*(2*k) +: 8], d[8*(2*k+1) +: 8]};
        end
        return s;
    endfunction

    function automatic logic [15:0] fold_sum(input logic [31:0] s);
        logic [31:0] f;
        f = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
        f = {16'h0000, f[15:0]} + {16'h0000, f[31:16]};
        return f[15:0];
    endfunction

    function automatic logic is_linear(input logic [DATA_WIDTH-1:0] d);
        for (int i = 0; i < BYTE_WIDTH - 1; i++) begin
            if (d[8*(i+1) +: 8] != d[8*i +: 8] + 8'd1) return 1'b0;
        end
        return 1'b1;
    endfunction

    assign xfer        = i_valid & i_ready;
    assign ip_len      = {i_data[8*16 +: 8], i_data[8*17 +: 8]};
    // Last two IPv4 header bytes open the second beat
    assign second_word = {i_data[7:0], i_data[15:8]};

    // ------------------------------
    // Frame tracking
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            started_q  <= 1'b0;
            in_frame_q <= 1'b0;
            beats_q    <= '0;
        end else begin
            if (i_start) started_q <= 1'b1;
            if (xfer) begin
                if (i_sop) begin
                    in_frame_q  <= 1'b1;
                    beats_q     <= 16'd1;
                    frame_len_q <= ip_len + 16'(MAC_HDR_BYTES);
                    csum_part_q <= header_word_sum(i_data);
                end else begin
                    beats_q <= beats_q + 16'd1;
                end
                if (i_eop) in_frame_q <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_idle_before_start: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !started_q |-> !i_valid)
        else begin
            $error("valid before any start");
            error_count = error_count + 1;
        end

    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid && !i_ready |=> $stable(i_data) && $stable(i_sop) && $stable(i_eop)
                                && $stable(i_mod))
        else begin
            $error("beat changed under back-pressure");
            error_count = error_count + 1;
        end

    a_sop_outside_frame: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && i_sop |-> !in_frame_q)
        else begin
            $error("sop inside a frame");
            error_count = error_count + 1;
        end

    a_beat_inside_frame: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && !i_sop |-> in_frame_q)
        else begin
            $error("beat outside a frame");
            error_count = error_count + 1;
        end

    a_beat_count: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && i_eop |-> beats_q + 16'd1 == (frame_len_q + 16'd31) >> 5)
        else begin
            $error("wrong beat count");
            error_count = error_count + 1;
        end

    a_eop_mod: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && i_eop |-> i_mod == frame_len_q[4:0])
        else begin
            $error("wrong eop byte count");
            error_count = error_count + 1;
        end

    a_mod_zero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid && !i_eop |-> i_mod == '0)
        else begin
            $error("mod set off eop");
            error_count = error_count + 1;
        end

    a_checksum: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && !i_sop && beats_q == 16'd1 |->
            fold_sum(csum_part_q + {16'h0000, second_word}) == 16'hFFFF)
        else begin
            $error("bad IPv4 checksum");
            error_count = error_count + 1;
        end

    a_len_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && i_sop |-> ip_len >= 16'd46 && ip_len <= 16'd1500)
        else begin
            $error("IP length out of range");
            error_count = error_count + 1;
        end

    a_fixed_len: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && i_sop && !i_random_len |-> ip_len == i_fixed_len)
        else begin
            $error("IP length differs from fixed length");
            error_count = error_count + 1;
        end

    a_linear: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        xfer && !i_sop && i_linear_payload && beats_q >= 16'd2 |-> is_linear(i_data))
        else begin
            $error("linear payload broken");
            error_count = error_count + 1;
        end

    // A newly loaded sop or eop beat was issued in the previous cycle
    a_sop_enable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid && i_sop && !$past(i_valid && i_sop && !i_ready) |-> $past(i_enable))
        else begin
            $error("sop issued while disabled");
            error_count = error_count + 1;
        end

    a_eop_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid && i_eop && !$past(i_valid && i_eop && !i_ready) |-> !$past(i_hold_eop))
        else begin
            $error("eop issued during hold");
            error_count = error_count + 1;
        end

endmodule

// File: design/eth_pkt_gen.sv
// Top level of the Ethernet IPv4 test frame generator
`timescale 1ns/1ns

module eth_pkt_gen import eth_gen_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_start,
    input  logic                  i_enable,
    input  logic                  i_hold_eop,
    input  logic                  i_random_len,
    input  logic [LEN_WIDTH-1:0]  i_fixed_len,
    input  logic                  i_linear_payload,
    input  logic [31:0]           i_pkt_num,
    input  logic                  i_ready,
    output logic                  o_valid,
    output logic [DATA_WIDTH-1:0] o_data,
    output logic                  o_sop,
    output logic                  o_eop,
    output logic [MOD_WIDTH-1:0]  o_mod
);

    logic [LEN_WIDTH-1:0]  payload_len;
    logic                  load_len;
    logic [HDR_WIDTH-1:0]  header;
    logic                  payload_advance;
    logic [DATA_WIDTH-1:0] payload_word;

    tx_beat_if beat_if ();

    pkt_len_gen len_gen_i (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_random_len  (i_random_len),
        .i_fixed_len   (i_fixed_len),
        .o_payload_len (payload_len)
    );

    ipv4_header_build hdr_build_i (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_load_len    (load_len),
        .i_payload_len (payload_len),
        .o_header      (header)
    );

    payload_gen payload_gen_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_advance      (payload_advance),
        .i_linear       (i_linear_payload),
        .o_payload_word (payload_word)
    );

    pkt_tx_ctrl tx_ctrl_i (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_start           (i_start),
        .i_enable          (i_enable),
        .i_hold_eop        (i_hold_eop),
        .i_pkt_num         (i_pkt_num),
        .i_payload_len     (payload_len),
        .o_load_len        (load_len),
        .o_payload_advance (payload_advance),
        .beat              (beat_if.ctrl)
    );

    frame_assembler assembler_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_header       (header),
        .i_payload_word (payload_word),
        .i_ready        (i_ready),
        .beat           (beat_if.asm),
        .o_valid        (o_valid),
        .o_data         (o_data),
        .o_sop          (o_sop),
        .o_eop          (o_eop),
        .o_mod          (o_mod)
    );

endmodule

// File: design/frame_assembler.sv
// Output stage: beat forming, byte reversal and stream register
`timescale 1ns/1ns

module frame_assembler import eth_gen_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic [HDR_WIDTH-1:0]  i_header,
    input  logic [DATA_WIDTH-1:0] i_payload_word,
    input  logic                  i_ready,
    tx_beat_if.asm                beat,
    output logic                  o_valid,
    output logic [DATA_WIDTH-1:0] o_data,
    output logic                  o_sop,
    output logic                  o_eop,
    output logic [MOD_WIDTH-1:0]  o_mod
);

    logic [DATA_WIDTH-1:0] formed;
    logic [DATA_WIDTH-1:0] reversed;
    logic                  take;

    // Register free, or its beat leaves this cycle
    assign beat.can_accept = ~o_valid | i_ready;
    assign take            = beat.beat_valid & beat.can_accept;

    // Formed word is in frame order from the MSB down
    always_comb begin
        case (beat.beat_kind)
            BEAT_HEADER: formed = i_header[HDR_WIDTH-1 -: DATA_WIDTH];
            BEAT_SECOND: formed = {i_header[HDR_OVERFLOW_BITS-1:0],
                                   i_payload_word[DATA_WIDTH-1 -: DATA_WIDTH-HDR_OVERFLOW_BITS]};
            default:     formed = i_payload_word;
        endcase
    end

    // Frame byte 0 ends up in bits 7:0
    always_comb begin
        for (int i = 0; i < BYTE_WIDTH; i++) begin
            reversed[8*i +: 8] = formed[DATA_WIDTH-1-8*i -: 8];
        end
    end

    // ------------------------------
    // Stream register
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_valid <= 1'b0;
            o_sop   <= 1'b0;
            o_eop   <= 1'b0;
            o_mod   <= '0;
        end else if (take) begin
            o_valid <= 1'b1;
            o_sop   <= (beat.beat_kind == BEAT_HEADER);
            o_eop   <= beat.beat_last;
            o_mod   <= beat.beat_mod;
        end else if (i_ready) begin
            o_valid <= 1'b0;
            o_sop   <= 1'b0;
            o_eop   <= 1'b0;
            o_mod   <= '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_data <= reversed;
        end
    end

endmodule

// File: design/pkt_tx_ctrl.sv
// Frame controller: start detect, frame FSM, byte and packet counters
`timescale 1ns/1ns

module pkt_tx_ctrl import eth_gen_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_start,
    input  logic                 i_enable,
    input  logic                 i_hold_eop,
    input  logic [31:0]          i_pkt_num,
    input  logic [LEN_WIDTH-1:0] i_payload_len,
    output logic                 o_load_len,
    output logic                 o_payload_advance,
    tx_beat_if.ctrl              beat
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SOP,
        ST_PAYLOAD,
        ST_EOP,
        ST_GAP
    } state_t;

    state_t               state_q;
    state_t               state_d;
    logic [1:0]           start_sync_q;
    logic                 start_prev_q;
    logic                 start_pulse_q;
    logic [LEN_WIDTH-1:0] remain_q;
    logic [31:0]          pkt_cnt_q;
    logic                 second_pend_q;
    logic                 issue;
    logic                 more_after;
    logic                 limit_hit;

    // ------------------------------
    // Start synchronizer and edge
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            start_sync_q  <= '0;
            start_prev_q  <= 1'b0;
            start_pulse_q <= 1'b0;
        end else begin
            start_sync_q  <= {start_sync_q[0], i_start};
            start_prev_q  <= start_sync_q[1];
            start_pulse_q <= start_sync_q[1] & ~start_prev_q;
        end
    end

    // Length is sampled once per frame, header and byte count together
    assign o_load_len = (state_q == ST_IDLE && start_pulse_q) || state_q == ST_GAP;

    // ------------------------------
    // Beat commands
    // ------------------------------
    always_comb begin
        beat.beat_valid = 1'b0;
        beat.beat_kind  = second_pend_q ? BEAT_SECOND : BEAT_PAYLOAD;
        case (state_q)
            ST_SOP: begin
                beat.beat_valid = i_enable;
                beat.beat_kind  = BEAT_HEADER;
            end
            ST_PAYLOAD: beat.beat_valid = 1'b1;
            ST_EOP:     beat.beat_valid = ~i_hold_eop;
            default:    beat.beat_valid = 1'b0;
        endcase
    end

    // A mod of 0 on a full last beat falls out of the low bits
    assign beat.beat_last = (remain_q <= LEN_WIDTH'(BYTE_WIDTH));
    assign beat.beat_mod  = beat.beat_last ? remain_q[MOD_WIDTH-1:0] : '0;

    assign issue             = beat.beat_valid & beat.can_accept;
    assign o_payload_advance = issue && (beat.beat_kind != BEAT_HEADER);
    assign more_after        = (remain_q > LEN_WIDTH'(2 * BYTE_WIDTH));
    assign limit_hit         = (i_pkt_num != 32'd0) && (pkt_cnt_q == i_pkt_num);

    // ------------------------------
    // Frame FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_pulse_q) state_d = ST_SOP;
            end
            ST_SOP, ST_PAYLOAD: begin
                if (issue) state_d = more_after ? ST_PAYLOAD : ST_EOP;
            end
            ST_EOP: begin
                if (issue) state_d = ST_GAP;
            end
            ST_GAP:  state_d = limit_hit ? ST_IDLE : ST_SOP;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q       <= ST_IDLE;
            remain_q      <= '0;
            pkt_cnt_q     <= '0;
            second_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_load_len) begin
                remain_q <= i_payload_len + LEN_WIDTH'(MAC_HDR_BYTES);
            end else if (issue) begin
                remain_q <= remain_q - LEN_WIDTH'(BYTE_WIDTH);
            end
            // Packet count restarts on every start
            if (state_q == ST_IDLE && start_pulse_q) begin
                pkt_cnt_q <= '0;
            end else if (issue && state_q == ST_SOP) begin
                pkt_cnt_q <= pkt_cnt_q + 32'd1;
            end
            if (issue) begin
                second_pend_q <= (state_q == ST_SOP);
            end
        end
    end

endmodule

// File: design/payload_gen.sv
// Linear count or pseudo-random payload word generator
`timescale 1ns/1ns

module payload_gen import eth_gen_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_advance,
    input  logic                  i_linear,
    output logic [DATA_WIDTH-1:0] o_payload_word
);

    logic [7:0]            base_q;
    logic [15:0]           lfsr_q;
    logic [15:0]           chain [0:BYTE_WIDTH];
    logic [DATA_WIDTH-1:0] lin_word;
    logic [DATA_WIDTH-1:0] rnd_word;

    // Byte k counts from the MSB end, which is frame order
    always_comb begin
        chain[0] = lfsr_q;
        for (int k = 0; k < BYTE_WIDTH; k++) begin
            chain[k+1]                        = lfsr16_next(chain[k]);
            lin_word[DATA_WIDTH-1-8*k -: 8] = base_q + 8'(k);
            rnd_word[DATA_WIDTH-1-8*k -: 8] = chain[k][7:0];
        end
    end

    assign o_payload_word = i_linear ? lin_word : rnd_word;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            base_q <= '0;
            lfsr_q <= PAYLOAD_SEED;
        end else if (i_advance) begin
            base_q <= base_q + 8'(BYTE_WIDTH);
            lfsr_q <= chain[BYTE_WIDTH];
        end
    end

endmodule

// File: design/ipv4_header_build.sv
// MAC and IPv4 header builder with total length and checksum
`timescale 1ns/1ns

module ipv4_header_build import eth_gen_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_load_len,
    input  logic [LEN_WIDTH-1:0] i_payload_len,
    output logic [HDR_WIDTH-1:0] o_header
);

    logic [LEN_WIDTH-1:0] total_len_q;
    ip_header_t           ip_base;
    ip_header_t           ip_hdr;

    // Ethernet payload length already counts the IP header,
    // so it is the IP total length as is
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            total_len_q <= '0;
        end else if (i_load_len) begin
            total_len_q <= i_payload_len;
        end
    end

    always_comb begin
        ip_base           = IP_HEADER_DEFAULT;
        ip_base.total_len = total_len_q;
    end

    always_comb begin
        ip_hdr          = ip_base;
        ip_hdr.checksum = ip_checksum(ip_base);
    end

    // MAC header in the most significant bytes, frame byte 0 at the top
    assign o_header = {MAC_HEADER_DEFAULT, ip_hdr};

endmodule

// File: design/pkt_len_gen.sv
// Random payload length pipeline with fixed length select
`timescale 1ns/1ns

module pkt_len_gen import eth_gen_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_random_len,
    input  logic [LEN_WIDTH-1:0] i_fixed_len,
    output logic [LEN_WIDTH-1:0] o_payload_len
);

    logic [15:0]          lfsr_q;
    logic [31:0]          scaled_q;
    logic [31:0]          offset_q;
    logic [LEN_WIDTH-1:0] rand_len;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            lfsr_q <= LEN_LFSR_SEED;
        end else begin
            lfsr_q <= lfsr16_next(lfsr_q);
        end
    end

    // State times span is a 16.16 fixed-point fraction of the span
    always_ff @(posedge i_clk) begin
        scaled_q <= lfsr_q * LEN_SPAN;
        offset_q <= scaled_q + {MIN_PAYLOAD_LEN, 16'h0000};
    end

    // Round to nearest on the fraction MSB
    assign rand_len = offset_q[31:16] + {15'd0, offset_q[15]};

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_payload_len <= MIN_PAYLOAD_LEN;
        end else begin
            o_payload_len <= i_random_len ? rand_len : i_fixed_len;
        end
    end

endmodule

// File: design/tx_beat_if.sv
// Beat command interface between the frame controller and the frame assembler
`timescale 1ns/1ns

interface tx_beat_if import eth_gen_pkg::*; ();

    logic                 can_accept;
    logic                 beat_valid;
    beat_kind_t           beat_kind;
    logic                 beat_last;
    logic [MOD_WIDTH-1:0] beat_mod;

    // Command taken whenever beat_valid and can_accept are both high
    modport ctrl (
        input  can_accept,
        output beat_valid, beat_kind, beat_last, beat_mod
    );

    modport asm (
        output can_accept,
        input  beat_valid, beat_kind, beat_last, beat_mod
    );

endinterface

// File: design/eth_gen_pkg.sv
// Stream widths, frame lengths, header types and defaults, checksum and LFSR functions
package eth_gen_pkg;

    // ------------------------------
    // Stream and length constants
    // ------------------------------
    localparam int DATA_WIDTH = 256;
    localparam int BYTE_WIDTH = DATA_WIDTH / 8;
    localparam int MOD_WIDTH  = $clog2(BYTE_WIDTH);
    localparam int LEN_WIDTH  = 16;

    localparam logic [LEN_WIDTH-1:0] MIN_PAYLOAD_LEN = 16'd46;
    localparam logic [LEN_WIDTH-1:0] MAX_PAYLOAD_LEN = 16'd1500;
    localparam logic [LEN_WIDTH-1:0] LEN_SPAN        = MAX_PAYLOAD_LEN - MIN_PAYLOAD_LEN;

    localparam int MAC_HDR_BYTES     = 14;
    localparam int IP_HDR_BYTES      = 20;
    localparam int HDR_WIDTH         = (MAC_HDR_BYTES + IP_HDR_BYTES) * 8;
    // MAC plus IPv4 header is 34 bytes, so 2 bytes spill into the second beat
    localparam int HDR_OVERFLOW_BITS = HDR_WIDTH - DATA_WIDTH;

    localparam logic [15:0] LEN_LFSR_SEED = 16'h17C2;
    localparam logic [15:0] PAYLOAD_SEED  = 16'hACE1;

    // Kind of beat requested from the frame assembler
    typedef enum logic [1:0] {
        BEAT_HEADER,
        BEAT_SECOND,
        BEAT_PAYLOAD
    } beat_kind_t;

    // ------------------------------
    // Header layouts
    // ------------------------------
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
    } mac_header_t;

    typedef struct packed {
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] id;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ip_header_t;

    // Locally administered addresses, UDP over IPv4
    localparam mac_header_t MAC_HEADER_DEFAULT = '{
        dst_mac:   48'h02_00_00_00_00_01,
        src_mac:   48'h02_00_00_00_00_02,
        ethertype: 16'h0800
    };

    localparam ip_header_t IP_HEADER_DEFAULT = '{
        ver_ihl:    8'h45,
        tos:        8'h00,
        total_len:  16'h0000,
        id:         16'h1234,
        flags_frag: 16'h4000,
        ttl:        8'h40,
        protocol:   8'h11,
        checksum:   16'h0000,
        src_addr:   32'hC0A8_0001,
        dst_addr:   32'hC0A8_0002
    };

    // Ones-complement sum of the ten header words, inverted
    // Expects the checksum field of hdr to be zero
    function automatic logic [15:0] ip_checksum(input ip_header_t hdr);
        logic [159:0] flat;
        logic [31:0]  sum;
        flat = hdr;
        sum  = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0000, flat[16*i +: 16]};
        end
        // Two folds cover the carries of ten words
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        return ~sum[15:0];
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr16_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

endpackage
